/* source/lsuConfigPkg.sv */
// Queue sizing and datapath widths for the load-store unit.
// Index and count types follow LsqDepthDefault, and queue pointers wrap by
// overflow of lsqIndexT, so LsqDepth set at the top must equal that default.
`default_nettype none

package lsuConfigPkg;

	localparam int LsqDepthDefault = 8; // entries per queue
	localparam int AddrWidth = 32; // byte address
	localparam int DataWidth = 32; // one word per access
	localparam int LsqIndexWidth = $clog2(LsqDepthDefault);

	typedef logic [LsqIndexWidth-1:0] lsqIndexT; // id into either queue
	typedef logic [LsqIndexWidth:0] lsqCountT; // occupancy, reaches the full depth

endpackage

`default_nettype wire

/* source/lsuPacketPkg.sv */
// Packets passed between the core, the execute pipe and both queues.
// Word accesses only, with no sizes, exceptions or atomics.
`default_nettype none

package lsuPacketPkg;

	typedef enum logic {
		opLoad = 1'b0,
		opStore = 1'b1
	} memOpT;

	typedef struct packed {
		logic valid;
		memOpT op; // selects the target queue
	} dispatchPktT;

	typedef struct packed {
		memOpT op;
		lsuConfigPkg::lsqIndexT id; // ldq id for loads, stq id for stores
		logic [lsuConfigPkg::AddrWidth-1:0] addr;
		logic [lsuConfigPkg::DataWidth-1:0] data; // store data, ignored for loads
	} agenPktT;

	typedef struct packed {
		logic hit; // an older store supplies the data
		logic [lsuConfigPkg::DataWidth-1:0] data;
	} fwdResultT;

	typedef struct packed {
		logic valid;
		lsuConfigPkg::lsqIndexT ldId; // oldest load that read stale data
	} violationPktT;

	typedef struct packed {
		lsuConfigPkg::lsqIndexT ldId;
		logic [lsuConfigPkg::DataWidth-1:0] data;
		logic fwd; // data came from the store queue
	} wbPktT;

	typedef struct packed {
		logic [lsuConfigPkg::AddrWidth-1:0] addr;
		logic [lsuConfigPkg::DataWidth-1:0] data;
	} memWritePktT;

endpackage

`default_nettype wire

/* source/lsqPointerCtrl.sv */
// Circular head, tail and count of both queues, one dispatch per cycle.
// The core must not commit a load or free a store while that queue is empty.
`default_nettype none

module lsqPointerCtrl #(
	parameter int LsqDepth = lsuConfigPkg::LsqDepthDefault
) (
	input logic clk,
	input logic reset,
	input lsuPacketPkg::dispatchPktT dispatch_i,
	input logic dispatchValid_i,
	output logic dispatchReady_o,
	output lsuConfigPkg::lsqIndexT lsqId_o,
	output lsuConfigPkg::lsqIndexT lastStIndex_o,
	output logic lastStValid_o,
	output logic ldAlloc_o,
	output logic stAlloc_o,
	input logic commitLoad_i,
	input logic stqFree_i,
	output lsuConfigPkg::lsqIndexT ldqHead_o,
	output lsuConfigPkg::lsqIndexT stqHead_o,
	output lsuConfigPkg::lsqCountT ldqCount_o,
	output lsuConfigPkg::lsqCountT stqCount_o
);
	import lsuConfigPkg::*;
	import lsuPacketPkg::*;

	lsqIndexT ldqTail; // next free load entry
	lsqIndexT stqTail; // next free store entry
	logic isStore;
	logic dispatchFire;

	assign isStore = (dispatch_i.op == opStore);
	assign dispatchReady_o = isStore ? (stqCount_o != lsqCountT'(LsqDepth))
		: (ldqCount_o != lsqCountT'(LsqDepth)); // room in the target queue
	assign dispatchFire = dispatchValid_i & dispatch_i.valid & dispatchReady_o;
	assign ldAlloc_o = dispatchFire & ~isStore;
	assign stAlloc_o = dispatchFire & isStore;
	assign lsqId_o = isStore ? stqTail : ldqTail; // id handed back same cycle
	assign lastStIndex_o = stqTail - 1'b1; // youngest store dispatched so far
	assign lastStValid_o = (stqCount_o != '0); // that store is still queued

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ldqHead_o <= '0;
			ldqTail <= '0;
			stqHead_o <= '0;
			stqTail <= '0;
			ldqCount_o <= '0;
			stqCount_o <= '0;
		end
		else
		begin
			if (ldAlloc_o)
				ldqTail <= ldqTail + 1'b1;
			if (stAlloc_o)
				stqTail <= stqTail + 1'b1;
			if (commitLoad_i)
				ldqHead_o <= ldqHead_o + 1'b1;
			if (stqFree_i)
				stqHead_o <= stqHead_o + 1'b1; // head store written to memory
			ldqCount_o <= ldqCount_o + lsqCountT'(ldAlloc_o) - lsqCountT'(commitLoad_i);
			stqCount_o <= stqCount_o + lsqCountT'(stAlloc_o) - lsqCountT'(stqFree_i);
		end
	end

	// no allocation ever pushes a queue past its depth
	assert property (@(posedge clk) disable iff (reset)
		(ldqCount_o <= lsqCountT'(LsqDepth)) && (stqCount_o <= lsqCountT'(LsqDepth)));

	// retirement from core and memory only hits occupied queues
	assert property (@(posedge clk) disable iff (reset)
		(commitLoad_i |-> ldqCount_o != '0) and (stqFree_i |-> stqCount_o != '0));

endmodule

`default_nettype wire

/* source/storeQueue.sv */
// Store address and data storage, load forwarding and the committed-store write.
// Forwarding is speculative, stores whose address is still unknown are skipped.
// One memory write is outstanding at a time.
`default_nettype none

module storeQueue #(
	parameter int LsqDepth = lsuConfigPkg::LsqDepthDefault
) (
	input logic clk,
	input logic reset,
	input logic alloc_i,
	input lsuConfigPkg::lsqIndexT allocId_i,
	input lsuPacketPkg::agenPktT exec_i,
	input logic execValid_i,
	input logic [lsuConfigPkg::AddrWidth-1:0] ldAddr_i,
	input lsuConfigPkg::lsqIndexT ldLastSt_i,
	input logic ldValid_i,
	input lsuConfigPkg::lsqIndexT stqHead_i,
	input lsuConfigPkg::lsqCountT stqCount_i,
	output lsuPacketPkg::fwdResultT fwd_o,
	input logic commitStore_i,
	output logic commitReady_o,
	output lsuPacketPkg::memWritePktT memWr_o,
	output logic memWrValid_o,
	input logic memWrReady_i,
	output logic stqFree_o
);
	import lsuConfigPkg::*;
	import lsuPacketPkg::*;

	logic [LsqDepth-1:0] addrKnown; // set once the store has executed
	logic [AddrWidth-1:0] stAddr [LsqDepth];
	logic [DataWidth-1:0] stData [LsqDepth];
	logic wrPending; // head store waiting on memWrReady_i

	assign commitReady_o = ~wrPending;
	assign memWrValid_o = wrPending;
	assign memWr_o = '{addr: stAddr[stqHead_i], data: stData[stqHead_i]};
	assign stqFree_o = wrPending & memWrReady_i; // entry leaves on the transfer

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			addrKnown <= '0;
			wrPending <= 1'b0;
		end
		else
		begin
			if (alloc_i)
				addrKnown[allocId_i] <= 1'b0; // new store, address not yet known
			if (execValid_i)
				addrKnown[exec_i.id] <= 1'b1;
			if (commitStore_i && commitReady_o)
				wrPending <= 1'b1;
			else if (stqFree_o)
				wrPending <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (execValid_i)
		begin
			stAddr[exec_i.id] <= exec_i.addr;
			stData[exec_i.id] <= exec_i.data;
		end
	end

	// walk from the head up to the load's last older store
	always_comb
	begin : fwdSearch
		lsqIndexT idx;
		lsqIndexT ldPos;
		ldPos = ldLastSt_i - stqHead_i; // age slot of the last older store
		fwd_o = '0;
		for (int k = 0; k < LsqDepth; k++)
		begin
			idx = stqHead_i + lsqIndexT'(k);
			if (ldValid_i && (k <= int'(ldPos)) && (k < int'(stqCount_i))
				&& addrKnown[idx] && (stAddr[idx] == ldAddr_i))
			begin
				fwd_o.hit = 1'b1; // later slots overwrite, youngest wins
				fwd_o.data = stData[idx];
			end
		end
	end

	// a store only retires after its address reached the queue
	assert property (@(posedge clk) disable iff (reset)
		commitStore_i && commitReady_o |-> addrKnown[stqHead_i] && (stqCount_i != '0));

endmodule

`default_nettype wire

/* source/loadQueue.sv */
// Per-load last older store, address and executed flag, plus the check that
// flags a load which ran ahead of an older store to the same address.
// The violation is registered and appears one cycle after the store executes.
`default_nettype none

module loadQueue #(
	parameter int LsqDepth = lsuConfigPkg::LsqDepthDefault
) (
	input logic clk,
	input logic reset,
	input logic alloc_i,
	input lsuConfigPkg::lsqIndexT allocId_i,
	input lsuConfigPkg::lsqIndexT lastSt_i,
	input logic lastStValid_i,
	input lsuPacketPkg::agenPktT exec_i,
	input logic ldExecValid_i,
	input logic stExecValid_i,
	input logic commitLoad_i,
	input lsuConfigPkg::lsqIndexT ldqHead_i,
	input lsuConfigPkg::lsqIndexT stqHead_i,
	input logic stqFree_i,
	output lsuConfigPkg::lsqIndexT ldLastSt_o,
	output logic ldFwdValid_o,
	output lsuPacketPkg::violationPktT violation_o
);
	import lsuConfigPkg::*;
	import lsuPacketPkg::*;

	logic [LsqDepth-1:0] entryValid;
	logic [LsqDepth-1:0] executed;
	logic [LsqDepth-1:0] hasOlderSt; // recorded last store still queued
	lsqIndexT lastSt [LsqDepth];
	logic [AddrWidth-1:0] ldAddr [LsqDepth];
	violationPktT vioNext;

	assign ldLastSt_o = lastSt[exec_i.id]; // bounds the forward search
	assign ldFwdValid_o = ldExecValid_i & hasOlderSt[exec_i.id];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			entryValid <= '0;
			executed <= '0;
			hasOlderSt <= '0;
			violation_o <= '0;
		end
		else
		begin
			for (int i = 0; i < LsqDepth; i++)
				if (stqFree_i && (lastSt[i] == stqHead_i))
					hasOlderSt[i] <= 1'b0; // all its older stores retired
			if (commitLoad_i)
				entryValid[ldqHead_i] <= 1'b0;
			if (alloc_i)
			begin
				entryValid[allocId_i] <= 1'b1;
				executed[allocId_i] <= 1'b0;
				hasOlderSt[allocId_i] <= lastStValid_i
					& ~(stqFree_i & (lastSt_i == stqHead_i)); // same-cycle free
			end
			if (ldExecValid_i)
				executed[exec_i.id] <= 1'b1;
			violation_o <= vioNext;
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc_i)
			lastSt[allocId_i] <= lastSt_i;
		if (ldExecValid_i)
			ldAddr[exec_i.id] <= exec_i.addr;
	end

	// ages are taken relative to the store head
	always_comb
	begin : vioSearch
		lsqIndexT idx;
		lsqIndexT stPos;
		stPos = exec_i.id - stqHead_i;
		vioNext = '0;
		for (int k = LsqDepth - 1; k >= 0; k--)
		begin
			idx = ldqHead_i + lsqIndexT'(k);
			if (stExecValid_i && entryValid[idx] && executed[idx] && hasOlderSt[idx]
				&& (lsqIndexT'(lastSt[idx] - stqHead_i) >= stPos)
				&& (ldAddr[idx] == exec_i.addr))
			begin
				vioNext.valid = 1'b1; // lower slots written last, oldest load wins
				vioNext.ldId = idx;
			end
		end
	end

endmodule

`default_nettype wire

/* source/lsuExecPipe.sv */
// Two-stage execute pipe. Stage 1 routes the AGEN packet and issues the read,
// stage 2 presents the load write-back. Memory must answer exactly one cycle
// after memRdValid_o. Stores leave after stage 1 and produce no write-back.
`default_nettype none

module lsuExecPipe (
	input logic clk,
	input logic reset,
	input lsuPacketPkg::agenPktT agen_i,
	input logic agenValid_i,
	output logic agenReady_o,
	input lsuPacketPkg::fwdResultT fwd_i,
	output lsuPacketPkg::agenPktT exec_o,
	output logic [lsuConfigPkg::AddrWidth-1:0] memRdAddr_o,
	output logic memRdValid_o,
	input logic [lsuConfigPkg::DataWidth-1:0] memRdData_i,
	output lsuPacketPkg::wbPktT wb_o,
	output logic wbValid_o,
	input logic wbReady_i,
	output logic ldExecValid_o,
	output logic stExecValid_o
);
	import lsuConfigPkg::*;
	import lsuPacketPkg::*;

	logic s1Valid;
	agenPktT s1Pkt;
	logic s2Valid;
	lsqIndexT s2Id;
	fwdResultT s2Fwd; // forward result latched from stage 1
	logic s2First; // read data is on memRdData_i this cycle
	logic [DataWidth-1:0] s2MemData; // read data kept across a stall
	logic [DataWidth-1:0] memData;
	logic stall;

	assign stall = s2Valid & ~wbReady_i;
	assign agenReady_o = ~stall;
	assign exec_o = s1Pkt; // to both queues
	assign ldExecValid_o = s1Valid & ~stall & (s1Pkt.op == opLoad);
	assign stExecValid_o = s1Valid & ~stall & (s1Pkt.op == opStore);
	assign memRdAddr_o = s1Pkt.addr;
	assign memRdValid_o = ldExecValid_o; // only when the load moves on
	assign memData = s2First ? memRdData_i : s2MemData;
	assign wbValid_o = s2Valid;
	assign wb_o = '{ldId: s2Id, data: s2Fwd.hit ? s2Fwd.data : memData, fwd: s2Fwd.hit};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			s2First <= 1'b0;
		end
		else
		begin
			if (!stall)
			begin
				s1Valid <= agenValid_i;
				s2Valid <= ldExecValid_o;
			end
			s2First <= ldExecValid_o;
		end
	end

	always_ff @(posedge clk)
	begin
		if (agenValid_i && agenReady_o)
			s1Pkt <= agen_i;
		if (ldExecValid_o)
		begin
			s2Id <= s1Pkt.id;
			s2Fwd <= fwd_i;
		end
		if (s2Valid)
			s2MemData <= memData; // capture on the first stage-2 cycle
	end

	// stalled write-back holds its packet
	assert property (@(posedge clk) disable iff (reset)
		wbValid_o && !wbReady_i |=> wbValid_o && $stable(wb_o));

endmodule

`default_nettype wire

/* source/lsuTop.sv */
// Single-lane load-store unit with separate load and store queues.
// No recovery on misprediction, so the core drains or resets on a flush.
// LsqDepth must match lsuConfigPkg::LsqDepthDefault.
`default_nettype none

module lsuTop #(
	parameter int LsqDepth = lsuConfigPkg::LsqDepthDefault
) (
	input logic clk,
	input logic reset,
	input lsuPacketPkg::dispatchPktT dispatch_i,
	input logic dispatchValid_i,
	output logic dispatchReady_o,
	output lsuConfigPkg::lsqIndexT lsqId_o,
	input logic commitLoad_i,
	input logic commitStore_i,
	output logic commitReady_o,
	input lsuPacketPkg::agenPktT agen_i,
	input logic agenValid_i,
	output logic agenReady_o,
	output logic [lsuConfigPkg::AddrWidth-1:0] memRdAddr_o,
	output logic memRdValid_o,
	input logic [lsuConfigPkg::DataWidth-1:0] memRdData_i,
	output lsuPacketPkg::memWritePktT memWr_o,
	output logic memWrValid_o,
	input logic memWrReady_i,
	output lsuPacketPkg::wbPktT wb_o,
	output logic wbValid_o,
	input logic wbReady_i,
	output lsuPacketPkg::violationPktT violation_o,
	output lsuConfigPkg::lsqCountT ldqCount_o,
	output lsuConfigPkg::lsqCountT stqCount_o
);
	import lsuConfigPkg::*;
	import lsuPacketPkg::*;

	logic ldAlloc;
	logic stAlloc;
	logic lastStValid;
	logic stqFree; // head store written to memory
	logic ldExecValid;
	logic stExecValid;
	logic ldFwdValid;
	lsqIndexT lastSt;
	lsqIndexT ldqHead;
	lsqIndexT stqHead;
	lsqIndexT ldLastSt; // last older store of the executing load
	agenPktT execPkt; // stage-1 packet
	fwdResultT fwd;

	lsqPointerCtrl #(.LsqDepth(LsqDepth)) i_lsqPointerCtrl (
		.clk(clk),
		.reset(reset),
		.dispatch_i(dispatch_i),
		.dispatchValid_i(dispatchValid_i),
		.dispatchReady_o(dispatchReady_o),
		.lsqId_o(lsqId_o),
		.lastStIndex_o(lastSt),
		.lastStValid_o(lastStValid),
		.ldAlloc_o(ldAlloc),
		.stAlloc_o(stAlloc),
		.commitLoad_i(commitLoad_i),
		.stqFree_i(stqFree),
		.ldqHead_o(ldqHead),
		.stqHead_o(stqHead),
		.ldqCount_o(ldqCount_o),
		.stqCount_o(stqCount_o)
	);

	storeQueue #(.LsqDepth(LsqDepth)) i_storeQueue (
		.clk(clk),
		.reset(reset),
		.alloc_i(stAlloc),
		.allocId_i(lsqId_o),
		.exec_i(execPkt),
		.execValid_i(stExecValid),
		.ldAddr_i(memRdAddr_o),
		.ldLastSt_i(ldLastSt),
		.ldValid_i(ldFwdValid),
		.stqHead_i(stqHead),
		.stqCount_i(stqCount_o),
		.fwd_o(fwd),
		.commitStore_i(commitStore_i),
		.commitReady_o(commitReady_o),
		.memWr_o(memWr_o),
		.memWrValid_o(memWrValid_o),
		.memWrReady_i(memWrReady_i),
		.stqFree_o(stqFree)
	);

	loadQueue #(.LsqDepth(LsqDepth)) i_loadQueue (
		.clk(clk),
		.reset(reset),
		.alloc_i(ldAlloc),
		.allocId_i(lsqId_o),
		.lastSt_i(lastSt),
		.lastStValid_i(lastStValid),
		.exec_i(execPkt),
		.ldExecValid_i(ldExecValid),
		.stExecValid_i(stExecValid),
		.commitLoad_i(commitLoad_i),
		.ldqHead_i(ldqHead),
		.stqHead_i(stqHead),
		.stqFree_i(stqFree),
		.ldLastSt_o(ldLastSt),
		.ldFwdValid_o(ldFwdValid),
		.violation_o(violation_o)
	);

	lsuExecPipe i_lsuExecPipe (
		.clk(clk),
		.reset(reset),
		.agen_i(agen_i),
		.agenValid_i(agenValid_i),
		.agenReady_o(agenReady_o),
		.fwd_i(fwd),
		.exec_o(execPkt),
		.memRdAddr_o(memRdAddr_o),
		.memRdValid_o(memRdValid_o),
		.memRdData_i(memRdData_i),
		.wb_o(wb_o),
		.wbValid_o(wbValid_o),
		.wbReady_i(wbReady_i),
		.ldExecValid_o(ldExecValid),
		.stExecValid_o(stExecValid)
	);

endmodule

`default_nettype wire

/* verification/lsuTbModel.svh */
// Reference model of both queues, kept in program order by a dispatch sequence
// number instead of queue indices. Also holds the memory contents that the
// responder returns, unwritten words read as address XOR a seeded key.
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

int seed = 28973;
logic [31:0] memKey;
logic [31:0] memArr [logic [31:0]]; // words written by committed stores
int ldSeq [Depth];
logic [31:0] ldAddr [Depth];
bit ldExec [Depth];
int stSeq [Depth];
logic [31:0] stAddr [Depth];
logic [31:0] stData [Depth];
bit stKnown [Depth]; // address delivered by agen
int ldHead = 0;
int ldTail = 0;
int ldCnt = 0;
int stHead = 0;
int stTail = 0;
int stCnt = 0;
int seqNext = 0; // program order of dispatch
bit wrBusy = 0; // a store commit waits on memory
lsuPacketPkg::wbPktT expWb [$];
int expWbStep [$]; // step of agen acceptance
lsuPacketPkg::violationPktT vioPipe [2] = '{default: '0};

function automatic logic [31:0] memWord(input logic [31:0] a);
	if (memArr.exists(a))
		return memArr[a];
	return a ^ memKey;
endfunction

function automatic int allocate(input bit isStore);
	int id;
	if (isStore)
	begin
		id = stTail;
		stSeq[id] = seqNext;
		stKnown[id] = 0;
		stTail = (stTail + 1) % Depth;
		stCnt++;
	end
	else
	begin
		id = ldTail;
		ldSeq[id] = seqNext;
		ldExec[id] = 0;
		ldTail = (ldTail + 1) % Depth;
		ldCnt++;
	end
	seqNext++;
	return id;
endfunction

// youngest older store with a known, equal address supplies the data
function automatic void execLoad(input int id, input logic [31:0] addr, input int step);
	lsuPacketPkg::wbPktT exp;
	int idx;
	int best;
	best = -1;
	for (int k = 0; k < stCnt; k++)
	begin
		idx = (stHead + k) % Depth;
		if (stKnown[idx] && stSeq[idx] < ldSeq[id] && stAddr[idx] == addr
			&& (best < 0 || stSeq[idx] > stSeq[best]))
			best = idx;
	end
	exp.ldId = lsuConfigPkg::lsqIndexT'(id);
	exp.fwd = (best >= 0);
	exp.data = (best >= 0) ? stData[best] : memWord(addr);
	ldExec[id] = 1;
	ldAddr[id] = addr;
	expWb.push_back(exp);
	expWbStep.push_back(step);
endfunction

// oldest younger load that already read the same address
function automatic void execStore(input int id, input logic [31:0] addr,
	input logic [31:0] data);
	int idx;
	for (int k = ldCnt - 1; k >= 0; k--)
	begin
		idx = (ldHead + k) % Depth;
		if (ldExec[idx] && ldSeq[idx] > stSeq[id] && ldAddr[idx] == addr)
		begin
			vioPipe[0].valid = 1'b1; // older ones overwrite
			vioPipe[0].ldId = lsuConfigPkg::lsqIndexT'(idx);
		end
	end
	stKnown[id] = 1;
	stAddr[id] = addr;
	stData[id] = data;
endfunction

`endif

/* verification/lsuTb.sv */
// Testbench for lsuTop. One stimulus table step per clock, inputs driven 10
// units after the rising edge, outputs checked at the falling edge against the
// queue model. Table IDs assume depth 8 and a fresh reset.
`default_nettype none

module lsuTb;
	localparam int Depth = lsuConfigPkg::LsqDepthDefault;

	typedef struct packed {
		logic [1:0] dsp; // 0 idle, 1 load, 2 store
		logic [1:0] ag; // same coding for agen
		lsuConfigPkg::lsqIndexT id;
		logic [31:0] addr;
		logic [31:0] data;
		logic cl;
		logic cs;
		logic wr; // wbReady_i
		logic mw; // memWrReady_i
		logic [2:0] test;
	} stepT;

	logic clk;
	logic reset;
	lsuPacketPkg::dispatchPktT dispatch_i;
	logic dispatchValid_i;
	logic dispatchReady_o;
	lsuConfigPkg::lsqIndexT lsqId_o;
	logic commitLoad_i;
	logic commitStore_i;
	logic commitReady_o;
	lsuPacketPkg::agenPktT agen_i;
	logic agenValid_i;
	logic agenReady_o;
	logic [31:0] memRdAddr_o;
	logic memRdValid_o;
	logic [31:0] memRdData_i;
	lsuPacketPkg::memWritePktT memWr_o;
	logic memWrValid_o;
	logic memWrReady_i;
	lsuPacketPkg::wbPktT wb_o;
	logic wbValid_o;
	logic wbReady_i;
	lsuPacketPkg::violationPktT violation_o;
	lsuConfigPkg::lsqCountT ldqCount_o;
	lsuConfigPkg::lsqCountT stqCount_o;

	stepT steps [$];
	string testNames [7] = '{"", "ids and counts", "memory load", "forwarding",
		"violation", "commit", "back-pressure"};
	int curTest;
	logic rowWbReady;
	logic rowMemWrReady;
	int errors = 0;
	int testErrors = 0;
	bit prevStall = 0;
	lsuPacketPkg::wbPktT prevWb;
	logic [31:0] rdNext = '0; // read data for the next step
	bit rdPend = 0; // accepted load waits in stage 1 for its read
	logic [31:0] rdAddr = '0;

	`include "lsuTbModel.svh"

	lsuTop #(.LsqDepth(Depth)) i_lsuTop (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic reportFail(input string msg);
		errors++;
		$display("Fail at time %0t: %s", $time, msg);
	endtask

	task automatic addRow(input int dsp, input int ag, input int id, input logic [31:0] addr,
		input logic [31:0] data, input bit cl, input bit cs);
		stepT s;
		s = '{dsp: dsp, ag: ag, id: id, addr: addr, data: data, cl: cl, cs: cs,
			wr: rowWbReady, mw: rowMemWrReady, test: curTest};
		steps.push_back(s);
	endtask

	task automatic buildTable();
		rowWbReady = 1;
		rowMemWrReady = 1;
		curTest = 1; // fill both queues, then drain
		for (int i = 0; i < 9; i++)
			addRow(2, 0, 0, 0, 0, 0, 0); // ninth meets a full store queue
		for (int i = 0; i < 9; i++)
			addRow(1, 0, 0, 0, 0, 0, 0);
		for (int i = 0; i < 8; i++)
			addRow(0, 2, i, 'h100 + 4 * i, 'hA000 + i, 1, 0);
		for (int i = 0; i < 16; i++)
			addRow(0, 0, 0, 0, 0, 0, 1); // commit and write alternate
		curTest = 2;
		addRow(1, 0, 0, 0, 0, 0, 0);
		addRow(0, 1, 0, 'h40, 0, 0, 0);
		addRow(0, 0, 0, 0, 0, 0, 0);
		addRow(0, 0, 0, 0, 0, 0, 0);
		addRow(0, 0, 0, 0, 0, 1, 0);
		curTest = 3;
		addRow(2, 0, 0, 0, 0, 0, 0);
		addRow(2, 0, 0, 0, 0, 0, 0);
		addRow(2, 0, 0, 0, 0, 0, 0); // st2 stays unknown for now
		addRow(1, 0, 0, 0, 0, 0, 0);
		addRow(0, 2, 0, 'h80, 'hB0, 0, 0);
		addRow(0, 2, 1, 'h80, 'hB1, 0, 0);
		addRow(0, 1, 1, 'h80, 0, 0, 0); // should pick st1
		for (int i = 0; i < 3; i++)
			addRow(0, 0, 0, 0, 0, 0, 0);
		curTest = 4;
		addRow(1, 0, 0, 0, 0, 0, 0);
		addRow(2, 0, 0, 0, 0, 0, 0);
		addRow(1, 0, 0, 0, 0, 0, 0);
		addRow(0, 1, 2, 'hC0, 0, 0, 0);
		addRow(0, 1, 3, 'hC0, 0, 0, 0);
		addRow(0, 2, 3, 'hC0, 'hB3, 0, 0); // hits ld3 only
		addRow(0, 2, 2, 'hC0, 'hB2, 0, 0); // oldest of ld2, ld3
		for (int i = 0; i < 3; i++)
			addRow(0, 0, 0, 0, 0, 0, 0);
		curTest = 5;
		rowMemWrReady = 0; // first write held back
		for (int i = 0; i < 4; i++)
			addRow(0, 0, 0, 0, 0, i < 3, 1);
		rowMemWrReady = 1;
		for (int i = 0; i < 8; i++)
			addRow(0, 0, 0, 0, 0, 0, i < 7);
		curTest = 6;
		rowWbReady = 0;
		for (int i = 0; i < 3; i++)
			addRow(1, 0, 0, 0, 0, 0, 0);
		addRow(0, 1, 4, 'h104, 0, 0, 0);
		addRow(0, 1, 5, 'h108, 0, 0, 0);
		for (int i = 0; i < 3; i++)
			addRow(0, 0, 0, 0, 0, 0, 0);
		rowWbReady = 1;
		addRow(0, 1, 6, 'hC0, 0, 0, 0);
		for (int i = 0; i < 5; i++)
			addRow(0, 0, 0, 0, 0, i < 3, 0);
	endtask

	task automatic applyStep(input stepT s);
		dispatchValid_i = (s.dsp != 0);
		dispatch_i.valid = (s.dsp != 0);
		dispatch_i.op = (s.dsp == 2) ? lsuPacketPkg::opStore : lsuPacketPkg::opLoad;
		agenValid_i = (s.ag != 0);
		agen_i.op = (s.ag == 2) ? lsuPacketPkg::opStore : lsuPacketPkg::opLoad;
		agen_i.id = s.id;
		agen_i.addr = s.addr;
		agen_i.data = s.data;
		commitLoad_i = s.cl;
		commitStore_i = s.cs;
		wbReady_i = s.wr;
		memWrReady_i = s.mw;
	endtask

	// outputs are settled here, handshakes below are those of the coming edge
	task automatic sampleStep(input int r);
		stepT s;
		lsuPacketPkg::wbPktT exp;
		int accStep;
		int id;
		bit isSt;
		bit expS2;
		bit expRd;
		s = steps[r];
		isSt = (s.dsp == 2);
		expS2 = (expWb.size() != 0) && (expWbStep[0] + 2 <= r); // oldest load in stage 2
		expRd = rdPend && !(expS2 && !s.wr); // stage-1 load moves on
		if (ldqCount_o !== ldCnt || stqCount_o !== stCnt)
			reportFail($sformatf("counts %0d/%0d, expected %0d/%0d", ldqCount_o, stqCount_o,
				ldCnt, stCnt));
		if (dispatchReady_o !== ((isSt ? stCnt : ldCnt) < Depth))
			reportFail("dispatchReady_o does not match queue occupancy");
		if (commitReady_o !== !wrBusy)
			reportFail("commitReady_o wrong while a memory write is pending");
		if (memWrValid_o !== wrBusy)
			reportFail("memWrValid_o does not follow the pending store commit");
		if (wbValid_o !== expS2)
			reportFail($sformatf("wbValid_o %b, expected %b", wbValid_o, expS2));
		if (agenReady_o !== !(expS2 && !s.wr))
			reportFail("agenReady_o does not follow write-back stall");
		if (memRdValid_o !== expRd || (expRd && memRdAddr_o !== rdAddr))
			reportFail($sformatf("memory read %b/%h, expected %b/%h", memRdValid_o,
				memRdAddr_o, expRd, rdAddr));
		if (expRd)
			rdPend = 0;
		if (violation_o !== vioPipe[1])
			reportFail($sformatf("violation %h, expected %h", violation_o, vioPipe[1]));
		vioPipe[1] = vioPipe[0];
		vioPipe[0] = '0;
		if (prevStall && wb_o !== prevWb)
			reportFail("write-back changed while stalled");
		prevStall = wbValid_o && !wbReady_i;
		prevWb = wb_o;
		if (wbValid_o && wbReady_i)
		begin
			if (expWb.size() == 0)
				reportFail("write-back with no load outstanding");
			else
			begin
				exp = expWb.pop_front();
				accStep = expWbStep.pop_front();
				if (wb_o !== exp)
					reportFail($sformatf("write-back %h, expected %h (agen step %0d)", wb_o,
						exp, accStep));
			end
		end
		if (memWrValid_o && memWrReady_i)
		begin
			if (stCnt == 0 || memWr_o.addr !== stAddr[stHead] || memWr_o.data !== stData[stHead])
				reportFail($sformatf("memory write %h, expected store %0d", memWr_o, stHead));
			memArr[memWr_o.addr] = memWr_o.data;
			stHead = (stHead + 1) % Depth; // entry freed on the transfer
			stCnt--;
			wrBusy = 0;
		end
		if (commitStore_i && commitReady_o)
			wrBusy = 1;
		if (commitLoad_i)
		begin
			ldHead = (ldHead + 1) % Depth;
			ldCnt--;
		end
		if (dispatchValid_i && dispatchReady_o)
		begin
			id = allocate(isSt);
			if (lsqId_o !== id)
				reportFail($sformatf("lsqId_o %0d, expected %0d", lsqId_o, id));
		end
		if (agenValid_i && agenReady_o)
		begin
			if (s.ag == 2)
				execStore(s.id, s.addr, s.data);
			else
			begin
				execLoad(s.id, s.addr, r);
				rdPend = 1;
				rdAddr = s.addr;
			end
		end
		rdNext = memRdValid_o ? memWord(memRdAddr_o) : '0; // answered next step
	endtask

	initial
	begin
		reset = 1'b1;
		dispatch_i = '0;
		dispatchValid_i = 1'b0;
		commitLoad_i = 1'b0;
		commitStore_i = 1'b0;
		agen_i = '0;
		agenValid_i = 1'b0;
		memRdData_i = '0;
		memWrReady_i = 1'b0;
		wbReady_i = 1'b0;
		memKey = $random(seed);
		buildTable();
		repeat (8) @(posedge clk);
		for (int r = 0; r < steps.size(); r++)
		begin
			#10;
			reset = 1'b0;
			applyStep(steps[r]);
			memRdData_i = rdNext;
			@(negedge clk);
			sampleStep(r);
			if (r == steps.size() - 1 || steps[r + 1].test != steps[r].test)
			begin
				$display("Test %0d (%s) finished with %0d errors", steps[r].test,
					testNames[steps[r].test], errors - testErrors);
				testErrors = errors;
			end
			@(posedge clk);
		end
		if (expWb.size() != 0)
		begin
			errors++;
			$display("%0d loads never produced a write-back", expWb.size());
		end
		$display("Summary: %0d steps, %0d errors", steps.size(), errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// two cycles per table step plus the reset time
	initial
	begin
		wait (steps.size() > 0);
		#(steps.size() * 2 * 100 + 800);
		$display("Watchdog expired before the stimulus table finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verification
source/lsuConfigPkg.sv
source/lsuPacketPkg.sv
source/lsqPointerCtrl.sv
source/storeQueue.sv
source/loadQueue.sv
source/lsuExecPipe.sv
source/lsuTop.sv
verification/lsuTb.sv
